//--- src.f
common/coeff_regs_pkg.sv
rtl/coeff_addr_decode.sv
rtl/coeff_store.sv
rtl/coeff_readback.sv
rtl/coeff_ctrl_regs.sv
sim/coeff_ctrl_regs_assertions.sv
sim/tb_coeff_ctrl_regs.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_coeff_ctrl_regs
FILELIST := src.f
BUILD    := obj_dir

BIN     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD)

//--- sim/tb_coeff_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module tb_coeff_ctrl_regs;

  logic                                   clk;
  logic                                   rst_n;
  logic [coeff_regs_pkg::ADDR_W-1:0]      write_address;
  coeff_regs_pkg::coeff_t                 write_data;
  logic                                   write_en;
  logic [coeff_regs_pkg::ADDR_W-1:0]      read_address;
  coeff_regs_pkg::coeff_t                 read_data;
  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a1;
  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a2;
  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b0;
  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b1;
  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b2;
  coeff_regs_pkg::coeff_t [coeff_regs_pkg::FIR_TAPS-1:0]   fir_coeff;
  logic                                   filter_select;

  // Expected contents of every address
  coeff_regs_pkg::coeff_t             model [256] = '{default: '0};
  coeff_regs_pkg::coeff_t             exp_q [$];
  logic [coeff_regs_pkg::ADDR_W-1:0]  addr_q [$];
  logic [coeff_regs_pkg::ADDR_W-1:0]  unmapped_addrs [5] = '{8'h08, 8'h4F, 8'h70, 8'hF1, 8'hFF};
  logic [31:0]                        lfsr_state;
  int                                 errors = 0;
  int                                 checks = 0;
  int                                 reads_issued = 0;
  int                                 reads_done = 0;

  coeff_ctrl_regs i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .write_address (write_address),
    .write_data    (write_data),
    .write_en      (write_en),
    .read_address  (read_address),
    .read_data     (read_data),
    .coeff_a1      (coeff_a1),
    .coeff_a2      (coeff_a2),
    .coeff_b0      (coeff_b0),
    .coeff_b1      (coeff_b1),
    .coeff_b2      (coeff_b2),
    .fir_coeff     (fir_coeff),
    .filter_select (filter_select)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
  end

  //////////////////////////////////////////////////
  // Random data
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic coeff_regs_pkg::coeff_t random_word();
    coeff_regs_pkg::coeff_t word;
    word = '0;
    for (int b = 0; b < coeff_regs_pkg::DATA_W; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word = {word[coeff_regs_pkg::DATA_W-2:0], lfsr_state[0]};
    end
    return word;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic is_mapped(input logic [coeff_regs_pkg::ADDR_W-1:0] addr);
    int offset;
    offset = int'(addr) - int'(coeff_regs_pkg::FIR_BASE);
    if (addr == coeff_regs_pkg::CTRL_ADDR) begin
      return 1'b1;
    end
    if (offset >= 0 && offset < coeff_regs_pkg::FIR_TAPS) begin
      return 1'b1;
    end
    // IIR sections use only the lower half of each 16-word block
    return (addr < coeff_regs_pkg::FIR_BASE) && !addr[3];
  endfunction

  function automatic void model_write(input logic [coeff_regs_pkg::ADDR_W-1:0] addr,
                                      input coeff_regs_pkg::coeff_t data);
    if (addr == coeff_regs_pkg::CTRL_ADDR) begin
      model[addr] = {{(coeff_regs_pkg::DATA_W-1){1'b0}}, data[0]};
    end else if (is_mapped(addr)) begin
      model[addr] = data;
    end
  endfunction

  function automatic coeff_regs_pkg::coeff_t expected_read(
      input logic [coeff_regs_pkg::ADDR_W-1:0] addr);
    return is_mapped(addr) ? model[addr] : '0;
  endfunction

  //////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////

  task automatic check_value(input coeff_regs_pkg::coeff_t actual,
                             input coeff_regs_pkg::coeff_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s got 0x%04h, expected 0x%04h", $time, what, actual, expected);
    end
  endtask

  task automatic check_outputs(input string tag);
    int i;
    logic [coeff_regs_pkg::ADDR_W-1:0] offset;
    for (i = 0; i < coeff_regs_pkg::IIR_STAGES; i++) begin
      offset = i[coeff_regs_pkg::ADDR_W-1:0];
      check_value(coeff_a1[i[2:0]], model[coeff_regs_pkg::A1_BASE + offset],
                  $sformatf("%s coeff_a1[%0d]", tag, i));
      check_value(coeff_a2[i[2:0]], model[coeff_regs_pkg::A2_BASE + offset],
                  $sformatf("%s coeff_a2[%0d]", tag, i));
      check_value(coeff_b0[i[2:0]], model[coeff_regs_pkg::B0_BASE + offset],
                  $sformatf("%s coeff_b0[%0d]", tag, i));
      check_value(coeff_b1[i[2:0]], model[coeff_regs_pkg::B1_BASE + offset],
                  $sformatf("%s coeff_b1[%0d]", tag, i));
      check_value(coeff_b2[i[2:0]], model[coeff_regs_pkg::B2_BASE + offset],
                  $sformatf("%s coeff_b2[%0d]", tag, i));
    end
    for (i = 0; i < coeff_regs_pkg::FIR_TAPS; i++) begin
      offset = i[coeff_regs_pkg::ADDR_W-1:0];
      check_value(fir_coeff[i[4:0]], model[coeff_regs_pkg::FIR_BASE + offset],
                  $sformatf("%s fir_coeff[%0d]", tag, i));
    end
    check_value({15'h0000, filter_select}, model[coeff_regs_pkg::CTRL_ADDR],
                $sformatf("%s filter_select", tag));
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 40) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("ERROR: reset was not released within %0d cycles", cycles);
    end
  endtask

  task automatic wait_reads_done();
    int cycles;
    cycles = 0;
    while (reads_done != reads_issued && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (reads_done != reads_issued) begin
      errors++;
      $display("ERROR: %0d read checks never completed", reads_issued - reads_done);
    end
  endtask

  // One host cycle; expected read taken before this cycle's write hits the model
  task automatic drive_cycle(input logic we, input logic [coeff_regs_pkg::ADDR_W-1:0] waddr,
                             input coeff_regs_pkg::coeff_t wdata, input logic check,
                             input logic [coeff_regs_pkg::ADDR_W-1:0] raddr);
    @(posedge clk);
    #2;
    write_en      = we;
    write_address = waddr;
    write_data    = wdata;
    read_address  = raddr;
    if (check) begin
      exp_q.push_back(expected_read(raddr));
      addr_q.push_back(raddr);
      reads_issued++;
    end
    if (we) begin
      model_write(waddr, wdata);
    end
  endtask

  // Read sampled at this edge shows up by the falling edge
  initial begin : compare_reads
    coeff_regs_pkg::coeff_t            expected;
    logic [coeff_regs_pkg::ADDR_W-1:0] addr;
    forever begin
      @(posedge clk);
      if (exp_q.size() > 0) begin
        expected = exp_q.pop_front();
        addr     = addr_q.pop_front();
        @(negedge clk);
        check_value(read_data, expected, $sformatf("read_data at 0x%02h", addr));
        reads_done++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : run_test
    int                                a;
    int                                k;
    logic [coeff_regs_pkg::ADDR_W-1:0] addr;
    write_en      = 1'b0;
    write_address = 8'h00;
    write_data    = 16'h0000;
    read_address  = 8'h00;
    lfsr_state    = 32'hff4e;
    wait_reset_release();

    // Reset values everywhere
    check_outputs("reset");
    for (a = 0; a < 256; a++) begin
      addr = a[7:0];
      drive_cycle(1'b0, 8'h00, 16'h0000, 1'b1, addr);
    end

    // Fill every IIR and FIR word, then read all back
    for (a = 0; a < 256; a++) begin
      addr = a[7:0];
      if (is_mapped(addr) && addr != coeff_regs_pkg::CTRL_ADDR) begin
        drive_cycle(1'b1, addr, random_word(), 1'b0, 8'h00);
      end
    end
    for (a = 0; a < 256; a++) begin
      addr = a[7:0];
      if (is_mapped(addr) && addr != coeff_regs_pkg::CTRL_ADDR) begin
        drive_cycle(1'b0, 8'h00, 16'h0000, 1'b1, addr);
      end
    end
    check_outputs("after fill");

    // Holes in the map
    for (k = 0; k < 5; k++) begin
      drive_cycle(1'b1, unmapped_addrs[k], random_word(), 1'b0, 8'h00);
    end
    drive_cycle(1'b0, 8'h00, 16'h0000, 1'b0, 8'h00);
    check_outputs("after unmapped writes");
    for (k = 0; k < 5; k++) begin
      drive_cycle(1'b0, 8'h00, 16'h0000, 1'b1, unmapped_addrs[k]);
    end

    // Filter select keeps bit 0 only
    drive_cycle(1'b1, coeff_regs_pkg::CTRL_ADDR, 16'hFFFE, 1'b0, 8'h00);
    drive_cycle(1'b0, 8'h00, 16'h0000, 1'b1, coeff_regs_pkg::CTRL_ADDR);
    check_value({15'h0000, filter_select}, 16'h0000, "filter_select after 0xFFFE");
    drive_cycle(1'b1, coeff_regs_pkg::CTRL_ADDR, 16'h0003, 1'b0, 8'h00);
    drive_cycle(1'b0, 8'h00, 16'h0000, 1'b1, coeff_regs_pkg::CTRL_ADDR);
    check_value({15'h0000, filter_select}, 16'h0001, "filter_select after 0x0003");

    // Same-edge read and write, old value first
    addr = coeff_regs_pkg::B1_BASE + 8'h03;
    drive_cycle(1'b1, addr, random_word(), 1'b1, addr);
    drive_cycle(1'b0, 8'h00, 16'h0000, 1'b1, addr);
    addr = coeff_regs_pkg::FIR_BASE + 8'h11;
    drive_cycle(1'b1, addr, random_word(), 1'b1, addr);
    drive_cycle(1'b0, 8'h00, 16'h0000, 1'b1, addr);

    drive_cycle(1'b0, 8'h00, 16'h0000, 1'b0, 8'h00);
    wait_reads_done();
    check_outputs("final");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/coeff_ctrl_regs_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_ctrl_regs_assertions (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   write_en,
  input  logic [coeff_regs_pkg::ADDR_W-1:0]      write_address,
  input  coeff_regs_pkg::coeff_t                 read_data,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a1,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a2,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b0,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b1,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b2,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::FIR_TAPS-1:0]   fir_coeff,
  input  logic                                   filter_select
);

  logic iir_hit;
  logic fir_hit;
  logic ctrl_hit;
  logic write_unmapped;

  // Address classes of the write port
  assign iir_hit  = (write_address < coeff_regs_pkg::FIR_BASE) && !write_address[3];
  assign fir_hit  = (write_address - coeff_regs_pkg::FIR_BASE) < 8'(coeff_regs_pkg::FIR_TAPS);
  assign ctrl_hit = write_address == coeff_regs_pkg::CTRL_ADDR;
  assign write_unmapped = !(iir_hit || fir_hit || ctrl_hit);

  a_read_zero_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> read_data == '0)
    else $error("read_data not zero right after reset release");

  a_select_needs_ctrl_write: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(filter_select) |-> $past(write_en && ctrl_hit))
    else $error("filter_select changed without a control write");

  a_unmapped_write_ignored: assert property (@(posedge clk) disable iff (!rst_n)
    (write_en && write_unmapped) |=> $stable(coeff_a1) && $stable(coeff_a2)
      && $stable(coeff_b0) && $stable(coeff_b1) && $stable(coeff_b2)
      && $stable(fir_coeff) && $stable(filter_select))
    else $error("write to an unmapped address changed a coefficient output");

endmodule

bind coeff_ctrl_regs coeff_ctrl_regs_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .write_en      (write_en),
  .write_address (write_address),
  .read_data     (read_data),
  .coeff_a1      (coeff_a1),
  .coeff_a2      (coeff_a2),
  .coeff_b0      (coeff_b0),
  .coeff_b1      (coeff_b1),
  .coeff_b2      (coeff_b2),
  .fir_coeff     (fir_coeff),
  .filter_select (filter_select)
);

`default_nettype wire

//--- rtl/coeff_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_ctrl_regs (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Host write port
  input  logic [coeff_regs_pkg::ADDR_W-1:0]      write_address,
  input  coeff_regs_pkg::coeff_t                 write_data,
  input  logic                                   write_en,
  // Host read port
  input  logic [coeff_regs_pkg::ADDR_W-1:0]      read_address,
  output coeff_regs_pkg::coeff_t                 read_data,
  // Coefficients to the filter datapath
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a1,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a2,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b0,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b1,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b2,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::FIR_TAPS-1:0]   fir_coeff,
  output logic                                   filter_select
);

  coeff_regs_pkg::coeff_region_e          write_region;
  logic [coeff_regs_pkg::INDEX_W-1:0]     write_index;
  coeff_regs_pkg::coeff_region_e          read_region;
  logic [coeff_regs_pkg::INDEX_W-1:0]     read_index;

  //////////////////////////////////////////////////
  // Address decode, one per port
  //////////////////////////////////////////////////

  coeff_addr_decode u_write_decode (
    .address (write_address),
    .region  (write_region),
    .index   (write_index)
  );

  coeff_addr_decode u_read_decode (
    .address (read_address),
    .region  (read_region),
    .index   (read_index)
  );

  //////////////////////////////////////////////////
  // Storage and readback
  //////////////////////////////////////////////////

  coeff_store u_store (
    .clk           (clk),
    .rst_n         (rst_n),
    .write_en      (write_en),
    .write_region  (write_region),
    .write_index   (write_index),
    .write_data    (write_data),
    .coeff_a1      (coeff_a1),
    .coeff_a2      (coeff_a2),
    .coeff_b0      (coeff_b0),
    .coeff_b1      (coeff_b1),
    .coeff_b2      (coeff_b2),
    .fir_coeff     (fir_coeff),
    .filter_select (filter_select)
  );

  // Reads the same outputs that drive the filter
  coeff_readback u_readback (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_region   (read_region),
    .read_index    (read_index),
    .coeff_a1      (coeff_a1),
    .coeff_a2      (coeff_a2),
    .coeff_b0      (coeff_b0),
    .coeff_b1      (coeff_b1),
    .coeff_b2      (coeff_b2),
    .fir_coeff     (fir_coeff),
    .filter_select (filter_select),
    .read_data     (read_data)
  );

endmodule

`default_nettype wire

//--- rtl/coeff_readback.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_readback (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Decoded read address
  input  coeff_regs_pkg::coeff_region_e          read_region,
  input  logic [coeff_regs_pkg::INDEX_W-1:0]     read_index,
  // Stored values
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a1,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a2,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b0,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b1,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b2,
  input  coeff_regs_pkg::coeff_t [coeff_regs_pkg::FIR_TAPS-1:0]   fir_coeff,
  input  logic                                   filter_select,
  // Registered read data
  output coeff_regs_pkg::coeff_t                 read_data
);

  logic [coeff_regs_pkg::STAGE_W-1:0] stage;
  coeff_regs_pkg::coeff_t             read_next;

  assign stage = read_index[coeff_regs_pkg::STAGE_W-1:0];

  //////////////////////////////////////////////////
  // Read select
  //////////////////////////////////////////////////

  always_comb begin
    case (read_region)
      coeff_regs_pkg::REGION_A1:   read_next = coeff_a1[stage];
      coeff_regs_pkg::REGION_A2:   read_next = coeff_a2[stage];
      coeff_regs_pkg::REGION_B0:   read_next = coeff_b0[stage];
      coeff_regs_pkg::REGION_B1:   read_next = coeff_b1[stage];
      coeff_regs_pkg::REGION_B2:   read_next = coeff_b2[stage];
      coeff_regs_pkg::REGION_FIR:  read_next = fir_coeff[read_index];
      // Control word zero-extended
      coeff_regs_pkg::REGION_CTRL: read_next = {{(coeff_regs_pkg::DATA_W-1){1'b0}},
                                                filter_select};
      default:                     read_next = '0;
    endcase
  end

  // Samples the stored values before the same edge's write lands
  always_ff @(posedge clk or negedge rst_n) begin
    if (~rst_n) begin
      read_data <= '0;
    end else begin
      read_data <= read_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/coeff_store.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_store (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Decoded write port
  input  logic                                   write_en,
  input  coeff_regs_pkg::coeff_region_e          write_region,
  input  logic [coeff_regs_pkg::INDEX_W-1:0]     write_index,
  input  coeff_regs_pkg::coeff_t                 write_data,
  // IIR biquad sections
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a1,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_a2,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b0,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b1,
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::IIR_STAGES-1:0] coeff_b2,
  // FIR taps
  output coeff_regs_pkg::coeff_t [coeff_regs_pkg::FIR_TAPS-1:0]   fir_coeff,
  // Filter select
  output logic                                   filter_select
);

  logic [coeff_regs_pkg::STAGE_W-1:0] stage;

  // Decoder keeps IIR indices below IIR_STAGES
  assign stage = write_index[coeff_regs_pkg::STAGE_W-1:0];

  //////////////////////////////////////////////////
  // IIR coefficient storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (~rst_n) begin
      coeff_a1 <= '0;
      coeff_a2 <= '0;
      coeff_b0 <= '0;
      coeff_b1 <= '0;
      coeff_b2 <= '0;
    end else if (write_en) begin
      case (write_region)
        coeff_regs_pkg::REGION_A1: coeff_a1[stage] <= write_data;
        coeff_regs_pkg::REGION_A2: coeff_a2[stage] <= write_data;
        coeff_regs_pkg::REGION_B0: coeff_b0[stage] <= write_data;
        coeff_regs_pkg::REGION_B1: coeff_b1[stage] <= write_data;
        coeff_regs_pkg::REGION_B2: coeff_b2[stage] <= write_data;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // FIR taps and control
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (~rst_n) begin
      fir_coeff <= '0;
    end else if (write_en && write_region == coeff_regs_pkg::REGION_FIR) begin
      fir_coeff[write_index] <= write_data;
    end
  end

  // Only bit 0 of the control word is kept
  always_ff @(posedge clk or negedge rst_n) begin
    if (~rst_n) begin
      filter_select <= 1'b0;
    end else if (write_en && write_region == coeff_regs_pkg::REGION_CTRL) begin
      filter_select <= write_data[0];
    end
  end

endmodule

`default_nettype wire

//--- rtl/coeff_addr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_addr_decode (
  input  logic [coeff_regs_pkg::ADDR_W-1:0]  address,
  output coeff_regs_pkg::coeff_region_e      region,
  output logic [coeff_regs_pkg::INDEX_W-1:0] index
);

  // Start of the 8-word block holding this address
  logic [coeff_regs_pkg::ADDR_W-1:0] section_base;
  // Offset from the first tap, wraps for addresses below it
  logic [coeff_regs_pkg::ADDR_W-1:0] fir_offset;

  assign section_base = {address[coeff_regs_pkg::ADDR_W-1:coeff_regs_pkg::STAGE_W],
                         {coeff_regs_pkg::STAGE_W{1'b0}}};
  assign fir_offset   = address - coeff_regs_pkg::FIR_BASE;

  always_comb begin
    region = coeff_regs_pkg::REGION_NONE;
    index  = '0;
    if (address == coeff_regs_pkg::CTRL_ADDR) begin
      region = coeff_regs_pkg::REGION_CTRL;
    end else if (fir_offset[coeff_regs_pkg::ADDR_W-1:coeff_regs_pkg::INDEX_W] == '0) begin
      // In range when the offset fits in the tap index
      region = coeff_regs_pkg::REGION_FIR;
      index  = fir_offset[coeff_regs_pkg::INDEX_W-1:0];
    end else begin
      // Upper half of each IIR block (0x08-0x0F etc.) matches no base
      case (section_base)
        coeff_regs_pkg::A1_BASE: region = coeff_regs_pkg::REGION_A1;
        coeff_regs_pkg::A2_BASE: region = coeff_regs_pkg::REGION_A2;
        coeff_regs_pkg::B0_BASE: region = coeff_regs_pkg::REGION_B0;
        coeff_regs_pkg::B1_BASE: region = coeff_regs_pkg::REGION_B1;
        coeff_regs_pkg::B2_BASE: region = coeff_regs_pkg::REGION_B2;
        default:                 region = coeff_regs_pkg::REGION_NONE;
      endcase
      if (region != coeff_regs_pkg::REGION_NONE) begin
        index = {{(coeff_regs_pkg::INDEX_W - coeff_regs_pkg::STAGE_W){1'b0}},
                 address[coeff_regs_pkg::STAGE_W-1:0]};
      end
    end
  end

endmodule

`default_nettype wire

//--- common/coeff_regs_pkg.sv
`default_nettype none

package coeff_regs_pkg;

  //////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////

  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;

  localparam int IIR_STAGES = 8;
  localparam int FIR_TAPS   = 32;

  // Stage select within one IIR section
  localparam int STAGE_W = $clog2(IIR_STAGES);
  // Index within a region, sized for the FIR taps
  localparam int INDEX_W = $clog2(FIR_TAPS);

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  // IIR sections, IIR_STAGES words each
  localparam logic [ADDR_W-1:0] A1_BASE = 8'h00;
  localparam logic [ADDR_W-1:0] A2_BASE = 8'h10;
  localparam logic [ADDR_W-1:0] B0_BASE = 8'h20;
  localparam logic [ADDR_W-1:0] B1_BASE = 8'h30;
  localparam logic [ADDR_W-1:0] B2_BASE = 8'h40;

  // FIR taps run 0x50 to 0x6F
  localparam logic [ADDR_W-1:0] FIR_BASE = 8'h50;

  // Filter select, bit 0 only
  localparam logic [ADDR_W-1:0] CTRL_ADDR = 8'hF0;

  typedef logic [DATA_W-1:0] coeff_t;

  typedef enum logic [2:0] {
    REGION_A1,
    REGION_A2,
    REGION_B0,
    REGION_B1,
    REGION_B2,
    REGION_FIR,
    REGION_CTRL,
    REGION_NONE
  } coeff_region_e;

endpackage

`default_nettype wire
